// ==== periph_hub_cfg.svh ====
// Address map and width settings for the peripheral hub.
// Included by the package and by every module that needs a bus width,
// a slot number or a register offset.

`ifndef PERIPH_HUB_CFG_SVH
`define PERIPH_HUB_CFG_SVH

// Bus widths
`define HUB_ADDR_W        11
`define HUB_DATA_W        32
`define HUB_PINS          8

// Slot counts for the two address regions
`define HUB_FULL_SLOTS    16
`define HUB_SIMPLE_SLOTS  16

// Populated slots
`define HUB_GPIO_SLOT     1
`define HUB_EDGE_SLOT     1

// GPIO register offsets within its 64-byte window
`define GPIO_OUT_OFS      6'h00
`define GPIO_IN_OFS       6'h04
`define GPIO_SEL_OFS      6'h20

// Edge counter register offsets within its 16-byte window
`define EDGE_COUNT_OFS    4'h0
`define EDGE_PIN_OFS      4'h1

`endif

// ==== periph_hub_pkg.sv ====
// Shared bus types for the peripheral hub.
// Modules refer to these by scoped name, e.g. periph_hub_pkg::bus_req_t.

`include "periph_hub_cfg.svh"

package periph_hub_pkg;

    // Access size code used for both reads and writes
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_e;

    // Request from the core data bus
    typedef struct packed {
        logic [`HUB_ADDR_W-1:0] addr;
        logic [`HUB_DATA_W-1:0] wdata;
        access_e                write;
        access_e                read;
    } bus_req_t;

    // Read response from one slot
    typedef struct packed {
        logic [`HUB_DATA_W-1:0] rdata;
        logic                   ready;
    } slot_resp_t;

    // Output function select for one pin
    typedef struct packed {
        logic       is_simple;
        logic [3:0] slot;
    } pin_func_t;

endpackage

// ==== periph_addr_decode.sv ====
// Address decoder and response multiplexer for the peripheral hub.
// Bits 10:9 of 00/01 pick one of 16 full slots (64 bytes each),
// 10 picks one of 16 byte slots (16 bytes each). Purely combinational.

`timescale 1ns/100ps

`include "periph_hub_cfg.svh"

module periph_addr_decode (
    input  logic [`HUB_ADDR_W-1:0]      i_addr,
    input  periph_hub_pkg::slot_resp_t  i_full_resp [`HUB_FULL_SLOTS],
    input  logic [7:0]                  i_simple_rdata [`HUB_SIMPLE_SLOTS],
    output logic [`HUB_FULL_SLOTS-1:0]  o_full_sel,
    output logic [`HUB_SIMPLE_SLOTS-1:0] o_simple_sel,
    output periph_hub_pkg::slot_resp_t  o_resp
);

    logic [3:0] full_idx;
    logic [3:0] simple_idx;

    // Slot index fields of the address
    assign full_idx   = i_addr[9:6];
    assign simple_idx = i_addr[7:4];

    always_comb begin
        o_full_sel   = '0;
        o_simple_sel = '0;
        o_resp       = '0;

        case (i_addr[10:9])
            2'b00, 2'b01: begin
                o_full_sel[full_idx] = 1'b1;
                o_resp               = i_full_resp[full_idx];
            end
            2'b10: begin
                // Byte slots answer at once, data in the low byte
                o_simple_sel[simple_idx] = 1'b1;
                o_resp.rdata             = {{(`HUB_DATA_W-8){1'b0}}, i_simple_rdata[simple_idx]};
                o_resp.ready             = 1'b1;
            end
            default: begin
                // Region 11 is not mapped; nothing is selected
                o_resp = '0;
            end
        endcase
    end

endmodule

// ==== periph_read_buffer.sv ====
// Registered read path between the core and the peripheral slots.
// Captures the first ready response to a read and holds it until the core
// pulses read-complete. Writes are acknowledged in the same cycle.

`timescale 1ns/100ps

`include "periph_hub_cfg.svh"

module periph_read_buffer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  periph_hub_pkg::bus_req_t     i_req,
    input  logic                         i_read_complete,
    input  periph_hub_pkg::slot_resp_t   i_resp,
    output periph_hub_pkg::access_e      o_slot_read,
    output logic [`HUB_DATA_W-1:0]       o_rdata,
    output logic                         o_ready
);

    logic                   read_req;
    logic                   write_req;
    logic                   capture;
    logic                   hold_r;
    logic                   ready_r;
    logic [`HUB_DATA_W-1:0] rdata_r;

    assign read_req  = (i_req.read != periph_hub_pkg::ACC_NONE);
    assign write_req = (i_req.write != periph_hub_pkg::ACC_NONE);

    // Take the response only once per read
    assign capture = !hold_r && read_req && i_resp.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_r  <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_r <= 1'b0;
            end
            if (capture) begin
                hold_r <= 1'b1;
            end
            // Data is registered, so ready has to be as well
            ready_r <= read_req && i_resp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_r <= i_resp.rdata;
        end
    end

    // Block a second read reaching the slots while the result waits
    assign o_slot_read = ready_r ? periph_hub_pkg::ACC_NONE : i_req.read;

    assign o_rdata = rdata_r;
    assign o_ready = ready_r || write_req;

endmodule

// ==== periph_gpio.sv ====
// GPIO peripheral on a full slot.
// Holds the output register and one function select per output pin.
// Each output pin is driven from the same-numbered bit of the slot its
// function select names; after reset every pin selects the GPIO itself.
// Register map: 0x00 output, 0x04 input, 0x20 + 4*pin function select.

`timescale 1ns/100ps

`include "periph_hub_cfg.svh"

module periph_gpio (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_sel,
    input  logic [5:0]                  i_offset,
    input  logic [`HUB_DATA_W-1:0]      i_wdata,
    input  periph_hub_pkg::access_e     i_write,
    input  logic [`HUB_PINS-1:0]        i_ui_in,
    input  logic [`HUB_PINS-1:0]        i_simple_pins,
    output periph_hub_pkg::slot_resp_t  o_resp,
    output logic [`HUB_PINS-1:0]        o_uo_out
);

    // Bits 4:2 of the offset index the function select registers
    localparam logic [5:0] SEL_IDX_MASK = 6'h1c;

    localparam int FUNC_W = $bits(periph_hub_pkg::pin_func_t);

    logic                     wr_en;
    logic                     out_hit;
    logic                     in_hit;
    logic                     sel_hit;
    logic [2:0]               sel_idx;
    logic [`HUB_PINS-1:0]     out_r;
    periph_hub_pkg::pin_func_t func_r [`HUB_PINS];

    assign wr_en   = i_sel && (i_write != periph_hub_pkg::ACC_NONE);
    assign out_hit = (i_offset == `GPIO_OUT_OFS);
    assign in_hit  = (i_offset == `GPIO_IN_OFS);
    assign sel_hit = ((i_offset & ~SEL_IDX_MASK) == `GPIO_SEL_OFS);
    assign sel_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_r <= '0;
        end else if (wr_en && out_hit) begin
            out_r <= i_wdata[`HUB_PINS-1:0];
        end
    end

    genvar pin;
    generate
        for (pin = 0; pin < `HUB_PINS; pin++) begin : g_pin
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    func_r[pin].is_simple <= 1'b0;
                    func_r[pin].slot      <= 4'(`HUB_GPIO_SLOT);
                end else if (wr_en && sel_hit && (sel_idx == pin)) begin
                    func_r[pin] <= i_wdata[FUNC_W-1:0];
                end
            end

            // Output routing for this pin
            always_comb begin
                o_uo_out[pin] = 1'b0;
                if (func_r[pin].is_simple) begin
                    if (func_r[pin].slot == 4'(`HUB_EDGE_SLOT)) begin
                        o_uo_out[pin] = i_simple_pins[pin];
                    end
                end else if (func_r[pin].slot == 4'(`HUB_GPIO_SLOT)) begin
                    o_uo_out[pin] = out_r[pin];
                end
            end
        end
    endgenerate

    // Read mux, always ready
    always_comb begin
        o_resp.ready = 1'b1;
        if (out_hit) begin
            o_resp.rdata = {{(`HUB_DATA_W-`HUB_PINS){1'b0}}, out_r};
        end else if (in_hit) begin
            o_resp.rdata = {{(`HUB_DATA_W-`HUB_PINS){1'b0}}, i_ui_in};
        end else if (sel_hit) begin
            o_resp.rdata = {{(`HUB_DATA_W-FUNC_W){1'b0}}, func_r[sel_idx]};
        end else begin
            o_resp.rdata = '0;
        end
    end

endmodule

// ==== periph_edge_counter.sv ====
// Rising-edge counter on a byte slot.
// Counts rising edges on one input pin picked by a 3-bit pin select.
// Offset 0 reads the 8-bit wrapping count, a write there clears it.
// Offset 1 holds the pin select. The count is also driven on the pins.

`timescale 1ns/100ps

`include "periph_hub_cfg.svh"

module periph_edge_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_sel,
    input  logic [3:0]               i_offset,
    input  periph_hub_pkg::access_e  i_write,
    input  logic [7:0]               i_wdata,
    input  logic [`HUB_PINS-1:0]     i_ui_in,
    output logic [7:0]               o_rdata,
    output logic [`HUB_PINS-1:0]     o_uo_out
);

    logic       wr_en;
    logic       count_hit;
    logic       pin_hit;
    logic [2:0] pin_sel_r;
    logic       sample_r;
    logic       prev_r;
    logic       rise;
    logic [7:0] count_r;

    assign wr_en     = i_sel && (i_write != periph_hub_pkg::ACC_NONE);
    assign count_hit = (i_offset == `EDGE_COUNT_OFS);
    assign pin_hit   = (i_offset == `EDGE_PIN_OFS);

    // Edge detect runs on the registered sample
    assign rise = sample_r && !prev_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel_r <= '0;
            sample_r  <= 1'b0;
            prev_r    <= 1'b0;
            count_r   <= '0;
        end else begin
            sample_r <= i_ui_in[pin_sel_r];
            prev_r   <= sample_r;

            if (wr_en && pin_hit) begin
                pin_sel_r <= i_wdata[2:0];
            end

            // Clearing wins over an edge in the same cycle
            if (wr_en && count_hit) begin
                count_r <= '0;
            end else if (rise) begin
                count_r <= count_r + 8'd1;
            end
        end
    end

    always_comb begin
        if (count_hit) begin
            o_rdata = count_r;
        end else if (pin_hit) begin
            o_rdata = {5'b0, pin_sel_r};
        end else begin
            o_rdata = '0;
        end
    end

    assign o_uo_out = count_r;

endmodule

// ==== periph_hub_top.sv ====
// Top level of the peripheral hub.
// Connects the core data bus to the read buffer and address decoder, and
// those to the GPIO (full slot 1) and the edge counter (byte slot 1).
// Every other slot is tied to an empty response here.

`timescale 1ns/100ps

`include "periph_hub_cfg.svh"

module periph_hub_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`HUB_PINS-1:0]        i_ui_in,
    input  periph_hub_pkg::bus_req_t    i_req,
    input  logic                        i_read_complete,
    output logic [`HUB_DATA_W-1:0]      o_rdata,
    output logic                        o_ready,
    output logic [`HUB_PINS-1:0]        o_uo_out
);

    wire periph_hub_pkg::slot_resp_t full_resp [`HUB_FULL_SLOTS];
    wire [7:0]                       simple_rdata [`HUB_SIMPLE_SLOTS];
    logic [`HUB_FULL_SLOTS-1:0]      full_sel;
    logic [`HUB_SIMPLE_SLOTS-1:0]    simple_sel;
    periph_hub_pkg::slot_resp_t      dec_resp;
    logic [`HUB_PINS-1:0]            edge_pins;

    periph_read_buffer u_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (i_req),
        .i_read_complete (i_read_complete),
        .i_resp          (dec_resp),
        .o_slot_read     (),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready)
    );

    periph_addr_decode u_addr_decode (
        .i_addr         (i_req.addr),
        .i_full_resp    (full_resp),
        .i_simple_rdata (simple_rdata),
        .o_full_sel     (full_sel),
        .o_simple_sel   (simple_sel),
        .o_resp         (dec_resp)
    );

    periph_gpio u_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_sel         (full_sel[`HUB_GPIO_SLOT]),
        .i_offset      (i_req.addr[5:0]),
        .i_wdata       (i_req.wdata),
        .i_write       (i_req.write),
        .i_ui_in       (i_ui_in),
        .i_simple_pins (edge_pins),
        .o_resp        (full_resp[`HUB_GPIO_SLOT]),
        .o_uo_out      (o_uo_out)
    );

    periph_edge_counter u_edge_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_sel    (simple_sel[`HUB_EDGE_SLOT]),
        .i_offset (i_req.addr[3:0]),
        .i_write  (i_req.write),
        .i_wdata  (i_req.wdata[7:0]),
        .i_ui_in  (i_ui_in),
        .o_rdata  (simple_rdata[`HUB_EDGE_SLOT]),
        .o_uo_out (edge_pins)
    );

    // Empty full slots read zero and never become ready
    // Empty byte slots read zero; the decoder makes them ready
    genvar s;
    generate
        for (s = 0; s < `HUB_FULL_SLOTS; s++) begin : g_full_tie
            if (s != `HUB_GPIO_SLOT) begin : g_empty
                assign full_resp[s] = '0;
            end
        end
        for (s = 0; s < `HUB_SIMPLE_SLOTS; s++) begin : g_simple_tie
            if (s != `HUB_EDGE_SLOT) begin : g_empty
                assign simple_rdata[s] = '0;
            end
        end
    endgenerate

endmodule

// ==== tb_periph_hub.sv ====
// Self-checking testbench for the peripheral hub.
// Builds a table of bus operations with their expected results, then runs it
// in order: GPIO output and input, read hold, edge counting, pin routing and
// an empty byte slot. The run stops at the first mismatch.

`timescale 1ns/100ps

`include "periph_hub_cfg.svh"

module tb_periph_hub;

    localparam int CLK_HALF = 4;
    localparam int MAX_OPS  = 64;
    localparam int READ_TMO = 20;

    // Operation kinds in the table
    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_HOLD  = 2;
    localparam int OP_DRIVE = 3;
    localparam int OP_PULSE = 4;
    localparam int OP_PINS  = 5;

    localparam logic [3:0] GPIO_SLOT = 4'(`HUB_GPIO_SLOT);
    localparam logic [3:0] EDGE_SLOT = 4'(`HUB_EDGE_SLOT);
    localparam logic [3:0] EMPTY_BYTE_SLOT = 4'd5;

    // Function select values with the is-simple bit above the slot index
    localparam logic [31:0] ROUTE_EDGE = {27'd0, 1'b1, EDGE_SLOT};
    localparam logic [31:0] ROUTE_GPIO = {27'd0, 1'b0, GPIO_SLOT};

    logic                     clk;
    logic                     rst_n;
    logic [`HUB_PINS-1:0]     ui_in;
    periph_hub_pkg::bus_req_t req;
    logic                     read_complete;
    logic [`HUB_DATA_W-1:0]   rdata;
    logic                     ready;
    logic [`HUB_PINS-1:0]     uo_out;

    int                       op_kind [MAX_OPS];
    string                    op_name [MAX_OPS];
    logic [`HUB_ADDR_W-1:0]   op_addr [MAX_OPS];
    logic [31:0]              op_data [MAX_OPS];
    logic [31:0]              op_exp  [MAX_OPS];
    int                       n_ops;

    periph_hub_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_req           (req),
        .i_read_complete (read_complete),
        .o_rdata         (rdata),
        .o_ready         (ready),
        .o_uo_out        (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Full slot address with bit 10 low, slot in 9:6 and offset in 5:0
    function automatic logic [`HUB_ADDR_W-1:0] full_addr(input logic [3:0] slot,
                                                         input logic [5:0] ofs);
        full_addr = {1'b0, slot, ofs};
    endfunction

    // Byte slot address in region 10 with slot in 7:4 and offset in 3:0
    function automatic logic [`HUB_ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                         input logic [3:0] ofs);
        byte_addr = {2'b10, 1'b0, slot, ofs};
    endfunction

    function automatic logic [`HUB_ADDR_W-1:0] sel_addr(input logic [2:0] pin);
        sel_addr = full_addr(GPIO_SLOT, `GPIO_SEL_OFS + {1'b0, pin, 2'b00});
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s (%s) expected 0x%08h actual 0x%08h", name, what, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic add_op(input int kind, input string name, input logic [`HUB_ADDR_W-1:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
        op_kind[n_ops] = kind;
        op_name[n_ops] = name;
        op_addr[n_ops] = addr;
        op_data[n_ops] = data;
        op_exp[n_ops]  = exp;
        n_ops++;
    endtask

    task automatic build_table();
        logic [31:0] gpio_val;
        logic [31:0] ui_val;
        logic [31:0] edge_n;
        logic [31:0] edge_m;
        int          p;
        gpio_val = $urandom & 32'hff;
        ui_val   = $urandom & 32'hff;
        edge_n   = 32'd1 + ($urandom % 20);
        // Low nibble is the inverse of the GPIO low nibble, so every routed
        // pin differs from what the GPIO would drive; bit 4 keeps it nonzero
        edge_m   = 32'd16 + {28'd0, ~gpio_val[3:0]};

        add_op(OP_WRITE, "gpio out write", full_addr(GPIO_SLOT, `GPIO_OUT_OFS), gpio_val, '0);
        add_op(OP_READ, "gpio out read", full_addr(GPIO_SLOT, `GPIO_OUT_OFS), '0, gpio_val);
        add_op(OP_PINS, "gpio out pins", '0, '0, gpio_val);

        add_op(OP_DRIVE, "drive inputs", '0, ui_val, '0);
        add_op(OP_READ, "gpio in read", full_addr(GPIO_SLOT, `GPIO_IN_OFS), '0, ui_val);
        add_op(OP_HOLD, "gpio in hold", full_addr(GPIO_SLOT, `GPIO_IN_OFS), '0, ui_val);
        add_op(OP_READ, "gpio unused offset", full_addr(GPIO_SLOT, 6'h08), '0, '0);

        // Edge counter on pin 3; op_addr holds the pin for pulses
        add_op(OP_DRIVE, "inputs low", '0, '0, '0);
        add_op(OP_WRITE, "edge pin write", byte_addr(EDGE_SLOT, `EDGE_PIN_OFS), 32'd3, '0);
        add_op(OP_READ, "edge pin read", byte_addr(EDGE_SLOT, `EDGE_PIN_OFS), '0, 32'd3);
        add_op(OP_WRITE, "edge clear", byte_addr(EDGE_SLOT, `EDGE_COUNT_OFS), '0, '0);
        add_op(OP_PULSE, "edge pulses", 11'd3, edge_n, '0);
        add_op(OP_READ, "edge count read", byte_addr(EDGE_SLOT, `EDGE_COUNT_OFS), '0, edge_n);
        add_op(OP_WRITE, "edge clear again", byte_addr(EDGE_SLOT, `EDGE_COUNT_OFS), '0, '0);
        add_op(OP_READ, "edge count zero", byte_addr(EDGE_SLOT, `EDGE_COUNT_OFS), '0, '0);

        // Pins 0 to 3 follow the edge count while 4 to 7 stay on the GPIO
        add_op(OP_PULSE, "routing pulses", 11'd3, edge_m, '0);
        for (p = 0; p < 4; p++) begin
            add_op(OP_WRITE, "route pin write", sel_addr(3'(p)), ROUTE_EDGE, '0);
        end
        for (p = 0; p < 4; p++) begin
            add_op(OP_READ, "route pin read", sel_addr(3'(p)), '0, ROUTE_EDGE);
        end
        add_op(OP_READ, "pin 4 default select", sel_addr(3'd4), '0, ROUTE_GPIO);
        add_op(OP_PINS, "routed pins", '0, '0, {24'd0, gpio_val[7:4], edge_m[3:0]});

        add_op(OP_READ, "empty byte slot", byte_addr(EMPTY_BYTE_SLOT, 4'h0), '0, '0);
    endtask

    task automatic do_write(input string name, input logic [`HUB_ADDR_W-1:0] addr,
                            input logic [31:0] data);
        req.addr  = addr;
        req.wdata = data;
        req.write = periph_hub_pkg::ACC_WORD;
        #1;
        check_value(name, "write ack", 32'd1, 32'(ready));
        @(negedge clk);
        req.write = periph_hub_pkg::ACC_NONE;
    endtask

    task automatic wait_ready(input string name, output int cycles);
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (ready) begin
                done = 1'b1;
            end else if (cycles >= READ_TMO) begin
                $display("Timeout: o_ready never went high during %s", name);
                $display("RESULT: FAIL");
                $fatal(1, "Read timeout");
            end
        end
    endtask

    task automatic do_read(input string name, input logic [`HUB_ADDR_W-1:0] addr,
                           input logic [31:0] exp, input bit hold);
        int cycles;
        req.addr = addr;
        req.read = periph_hub_pkg::ACC_WORD;
        wait_ready(name, cycles);
        check_value(name, "read latency", 32'd1, 32'(cycles));
        check_value(name, "read data", exp, rdata);
        if (hold) begin
            // New input value must not reach the held result
            ui_in = ~ui_in;
            repeat (2) @(negedge clk);
            check_value(name, "held ready", 32'd1, 32'(ready));
            check_value(name, "held data", exp, rdata);
        end
        req.read      = periph_hub_pkg::ACC_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        check_value(name, "ready after complete", 32'd0, 32'(ready));
    endtask

    task automatic do_pulse(input logic [2:0] pin, input int count);
        int k;
        for (k = 0; k < count; k++) begin
            ui_in[pin] = 1'b1;
            @(negedge clk);
            ui_in[pin] = 1'b0;
            @(negedge clk);
        end
        // Let the sample and edge registers catch up
        repeat (2) @(negedge clk);
    endtask

    task automatic run_op(input int i);
        case (op_kind[i])
            OP_WRITE: do_write(op_name[i], op_addr[i], op_data[i]);
            OP_READ:  do_read(op_name[i], op_addr[i], op_exp[i], 1'b0);
            OP_HOLD:  do_read(op_name[i], op_addr[i], op_exp[i], 1'b1);
            OP_DRIVE: begin
                ui_in = op_data[i][`HUB_PINS-1:0];
                repeat (2) @(negedge clk);
            end
            OP_PULSE: do_pulse(op_addr[i][2:0], int'(op_data[i]));
            OP_PINS:  check_value(op_name[i], "output pins", op_exp[i], 32'(uo_out));
            default: begin
                $display("Unknown operation kind in table entry %0d", i);
                $display("RESULT: FAIL");
                $fatal(1, "Bad table entry");
            end
        endcase
    endtask

    initial begin
        int i;
        rst_n         = 1'b0;
        ui_in         = '0;
        req.addr      = '0;
        req.wdata     = '0;
        req.write     = periph_hub_pkg::ACC_NONE;
        req.read      = periph_hub_pkg::ACC_NONE;
        read_complete = 1'b0;
        n_ops         = 0;
        void'($urandom(28));
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("after reset", "ready", 32'd0, 32'(ready));
        check_value("after reset", "output pins", 32'd0, 32'(uo_out));

        for (i = 0; i < n_ops; i++) begin
            run_op(i);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== periph_hub.f ====
+incdir+.
periph_hub_pkg.sv
periph_addr_decode.sv
periph_read_buffer.sv
periph_gpio.sv
periph_edge_counter.sv
periph_hub_top.sv
tb_periph_hub.sv
